// File: pcie_dma_pkg.sv
// Shared widths, TLP codes, BAR0 register map and beat/config structs for the
// PCIe endpoint DMA driver. Every design file imports this package.
`default_nettype none

package pcie_dma_pkg;

    // ------------------------------------------------------------------------
    // Link and buffer geometry
    // ------------------------------------------------------------------------
    localparam int QW_W          = 64;                  // TRN data width
    localparam int BUF_AW        = 9;                   // Rx buffer qword address
    localparam int MWR_QWORDS    = 16;                  // Payload per memory write
    localparam int MWR_BYTES     = 128;
    localparam int MAX_RD_QWORDS = 64;
    localparam int RD_LEN_W      = 7;                   // Holds 1..64
    localparam int PAGE_BYTES    = 2 * 1024 * 1024;     // 2 MiB host page
    localparam int PAGE_OFS_W    = $clog2(PAGE_BYTES);  // Offset wraps at page end

    // fmt[1:0] + type[4:0]
    localparam logic [6:0] FMT_MWR64 = 7'b11_00000;     // 4DW header, with data
    localparam logic [6:0] FMT_MRD64 = 7'b01_00000;     // 4DW header, no data
    localparam logic [6:0] FMT_MWR32 = 7'b10_00000;     // Host register writes

    // BAR0 register numbers, address bits 5:2
    localparam logic [3:0] REG_RX_PAGE_LO   = 4'd0;
    localparam logic [3:0] REG_RX_PAGE_HI   = 4'd1;
    localparam logic [3:0] REG_TX_PAGE_LO   = 4'd2;
    localparam logic [3:0] REG_TX_PAGE_HI   = 4'd3;
    localparam logic [3:0] REG_TX_RD_QWORDS = 4'd4;
    localparam logic [3:0] REG_CTRL         = 4'd5;     // Bit 0 irq enable

    // ------------------------------------------------------------------------
    // Shared structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [QW_W-1:0] data;
        logic            sof;                           // Active high here
        logic            eof;
    } tlp_beat_t;

    typedef struct packed {
        logic [63:0] rx_page_addr;                      // Rx packet landing page
        logic [63:0] tx_page_addr;                      // Tx packet source page
        logic        irq_en;
    } host_cfg_t;

endpackage

`default_nettype wire

// File: host_reg_decoder.sv
// Watches the TRN RX link for one-DW host writes to BAR0 and turns them into
// the host configuration and a read-request start pulse for the Tx side.
`timescale 1ns/1ps
`default_nettype none

module host_reg_decoder import pcie_dma_pkg::*; (
    input  wire logic            trn_clk,
    input  wire logic            rst,
    input  wire logic [QW_W-1:0] trn_rd,
    input  wire logic            trn_rsof_n,
    input  wire logic            trn_reof_n,
    input  wire logic            trn_rsrc_rdy_n,
    input  wire logic [6:0]      trn_rbar_hit_n,
    output host_cfg_t            host_cfg,
    output logic                 tx_rd_start,
    output logic [RD_LEN_W-1:0]  tx_rd_qwords
);

    logic [1:0]  beat_cnt;                        // Beats of current TLP, saturating
    logic        wr_hit;                          // Beat 1 was a 1-DW MWr on BAR0
    logic        rx_vld;
    logic        wr_go;
    logic [3:0]  reg_num;
    logic [31:0] wr_dw;

    assign rx_vld  = !trn_rsrc_rdy_n;
    assign reg_num = trn_rd[37:34];               // Address bits 5:2, upper DW
    assign wr_dw   = trn_rd[31:0];                // Write data sits in the low DW
    assign wr_go   = rx_vld && trn_rsof_n && !trn_reof_n && wr_hit && beat_cnt == 2'd1;

    // ------------------------------------------------------------------------
    // Beat tracking and register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            beat_cnt     <= 2'd0;
            wr_hit       <= 1'b0;
            host_cfg     <= '0;
            tx_rd_qwords <= '0;
            tx_rd_start  <= 1'b0;
        end else begin
            tx_rd_start <= 1'b0;
            if (rx_vld) begin
                if (!trn_rsof_n) begin
                    beat_cnt <= 2'd1;
                    wr_hit   <= trn_rd[62:56] == FMT_MWR32 &&
                                trn_rd[41:32] == 10'd1 &&   // One DW of payload
                                !trn_rbar_hit_n[0] && trn_reof_n;
                end else if (beat_cnt != 2'd3) begin
                    beat_cnt <= beat_cnt + 2'd1;
                end
            end
            if (wr_go) begin
                case (reg_num)
                    REG_RX_PAGE_LO: host_cfg.rx_page_addr[31:0]  <= wr_dw;
                    REG_RX_PAGE_HI: host_cfg.rx_page_addr[63:32] <= wr_dw;
                    REG_TX_PAGE_LO: host_cfg.tx_page_addr[31:0]  <= wr_dw;
                    REG_TX_PAGE_HI: host_cfg.tx_page_addr[63:32] <= wr_dw;
                    REG_TX_RD_QWORDS: begin
                        // Out-of-range counts never start a read
                        if (wr_dw != 32'd0 && wr_dw <= MAX_RD_QWORDS) begin
                            tx_rd_qwords <= wr_dw[RD_LEN_W-1:0];
                            tx_rd_start  <= 1'b1;
                        end
                    end
                    REG_CTRL:       host_cfg.irq_en <= wr_dw[0];
                    default: ;                    // Unknown offset, dropped
                endcase
            end
        end
    end

    // Two beats per host write keep starts apart
    a_start_single: assert property (@(posedge trn_clk) disable iff (rst)
        tx_rd_start |=> !tx_rd_start);

endmodule

`default_nettype wire

// File: rx_mwr_tlp_gen.sv
// Moves committed receive-buffer data to the host Rx page as 128-byte memory
// writes. Payload is prefetched one address ahead with a skid register so a
// granted beat is always valid under back-pressure.
`timescale 1ns/1ps
`default_nettype none

module rx_mwr_tlp_gen import pcie_dma_pkg::*; (
    input  wire logic              trn_clk,
    input  wire logic              rst,
    input  wire logic [15:0]       cfg_completer_id,
    input  host_cfg_t              host_cfg,
    input  wire logic [BUF_AW-1:0] rx_commited_wr_addr,
    output logic [BUF_AW-1:0]      rx_commited_rd_addr,
    output logic [BUF_AW-1:0]      rx_rd_addr,
    input  wire logic [QW_W-1:0]   rx_rd_data,
    output logic                   req,
    input  wire logic              grant,
    input  wire logic              ready,
    output tlp_beat_t              beat,
    output logic                   irq_req
);

    logic                  busy;                  // TLP pending or in flight
    logic [4:0]            beat_idx;              // 0,1 header then payload
    logic [PAGE_OFS_W-1:0] page_ofs;
    logic                  rd_vld;                // Buffer data valid this cycle
    logic                  skid_vld;
    logic                  skid_vld_nx;
    logic [QW_W-1:0]       skid;
    logic [BUF_AW-1:0]     fill;
    logic [BUF_AW-1:0]     rd_ahead;              // Words fetched for this TLP
    logic                  take;
    logic                  take_pl;
    logic                  fetch;

    assign fill     = rx_commited_wr_addr - rx_commited_rd_addr;
    assign rd_ahead = rx_rd_addr - rx_commited_rd_addr;
    assign take     = grant && ready;
    assign take_pl  = take && beat_idx >= 5'd2;
    assign req      = busy;

    // Skid fills when live data is not consumed, or when the skid word goes out
    always_comb begin
        skid_vld_nx = skid_vld;
        if (skid_vld && take_pl)
            skid_vld_nx = rd_vld;
        else if (!skid_vld && !take_pl && rd_vld)
            skid_vld_nx = 1'b1;
    end

    // Never fetch into a full skid, at most 16 words per TLP
    assign fetch = busy && rd_ahead < MWR_QWORDS && !skid_vld_nx;

    // ------------------------------------------------------------------------
    // Beat mux
    // ------------------------------------------------------------------------
    always_comb begin
        beat.sof = beat_idx == 5'd0;
        beat.eof = beat_idx == 5'(MWR_QWORDS + 1);
        case (beat_idx)
            5'd0:    beat.data = {1'b0, FMT_MWR64, 14'd0, 10'(MWR_BYTES / 4),
                                  cfg_completer_id, 8'd0, 8'hff};
            5'd1:    beat.data = host_cfg.rx_page_addr + QW_W'(page_ofs);
            default: beat.data = skid_vld ? skid : rx_rd_data;
        endcase
    end

    always_ff @(posedge trn_clk) begin
        if (rd_vld && skid_vld_nx)
            skid <= rx_rd_data;
    end

    // ------------------------------------------------------------------------
    // Control and pointers
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            busy                <= 1'b0;
            beat_idx            <= 5'd0;
            page_ofs            <= '0;
            rd_vld              <= 1'b0;
            skid_vld            <= 1'b0;
            rx_rd_addr          <= '0;
            rx_commited_rd_addr <= '0;
            irq_req             <= 1'b0;
        end else begin
            irq_req  <= 1'b0;
            rd_vld   <= fetch;                    // One cycle buffer latency
            skid_vld <= skid_vld_nx;
            if (fetch)
                rx_rd_addr <= rx_rd_addr + 1'b1;
            if (!busy && fill >= MWR_QWORDS)
                busy <= 1'b1;
            if (take) begin
                if (beat.eof) begin
                    busy                <= 1'b0;
                    beat_idx            <= 5'd0;
                    rx_commited_rd_addr <= rx_commited_rd_addr + BUF_AW'(MWR_QWORDS);
                    page_ofs            <= page_ofs + PAGE_OFS_W'(MWR_BYTES);
                    irq_req             <= 1'b1;
                end else begin
                    beat_idx <= beat_idx + 5'd1;
                end
            end
        end
    end

    // Grant stays up and sof does not repeat inside a TLP
    a_sof_first: assert property (@(posedge trn_clk) disable iff (rst)
        grant && ready && !beat.eof |=> grant && !beat.sof);

endmodule

`default_nettype wire

// File: tx_mrd_req_gen.sv
// Issues one two-beat memory-read request per start pulse, reading packet data
// from the host Tx page. Tag and page offset advance after every request.
`timescale 1ns/1ps
`default_nettype none

module tx_mrd_req_gen import pcie_dma_pkg::*; (
    input  wire logic                trn_clk,
    input  wire logic                rst,
    input  wire logic [15:0]         cfg_completer_id,
    input  host_cfg_t                host_cfg,
    input  wire logic                tx_rd_start,
    input  wire logic [RD_LEN_W-1:0] tx_rd_qwords,
    output logic                     req,
    input  wire logic                grant,
    input  wire logic                ready,
    output tlp_beat_t                beat
);

    logic                  busy;
    logic                  beat_idx;              // 0 header, 1 address
    logic [RD_LEN_W-1:0]   rd_qwords;             // Latched at start
    logic [3:0]            tag;
    logic [PAGE_OFS_W-1:0] page_ofs;
    logic                  take;

    assign req  = busy;
    assign take = grant && ready;

    always_comb begin
        beat.sof  = !beat_idx;
        beat.eof  = beat_idx;
        beat.data = beat_idx ? host_cfg.tx_page_addr + QW_W'(page_ofs)
                             : {1'b0, FMT_MRD64, 14'd0, {2'b00, rd_qwords, 1'b0},
                                cfg_completer_id, 4'd0, tag, 8'hff};   // Length 2N DW
    end

    always_ff @(posedge trn_clk) begin
        if (!busy && tx_rd_start)
            rd_qwords <= tx_rd_qwords;
    end

    // ------------------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            busy     <= 1'b0;
            beat_idx <= 1'b0;
            tag      <= 4'd0;
            page_ofs <= '0;
        end else begin
            if (!busy && tx_rd_start)
                busy <= 1'b1;                     // Starts while busy are dropped
            if (take) begin
                beat_idx <= !beat_idx;
                if (beat_idx) begin
                    busy     <= 1'b0;
                    tag      <= tag + 4'd1;
                    page_ofs <= page_ofs + PAGE_OFS_W'({rd_qwords, 3'b000});
                end
            end
        end
    end

    // Decoder filters counts, requester trusts them
    a_qwords_range: assert property (@(posedge trn_clk) disable iff (rst)
        busy |-> rd_qwords inside {[1:MAX_RD_QWORDS]});

endmodule

`default_nettype wire

// File: tlp_tx_arbiter.sv
// Round-robin owner of the TRN TX link between the Rx writer and the Tx
// requester. Drives the active-low TX pins and the core interrupt.
`timescale 1ns/1ps
`default_nettype none

module tlp_tx_arbiter import pcie_dma_pkg::*; (
    input  wire logic  trn_clk,
    input  wire logic  rst,
    input  wire logic  rx_req,
    output logic       rx_grant,
    output logic       rx_ready,
    input  tlp_beat_t  rx_beat,
    input  wire logic  tx_req,
    output logic       tx_grant,
    output logic       tx_ready,
    input  tlp_beat_t  tx_beat,
    input  wire logic  irq_req,
    input  wire logic  irq_en,
    output logic [QW_W-1:0] trn_td,
    output logic       trn_tsof_n,
    output logic       trn_teof_n,
    output logic       trn_tsrc_rdy_n,
    input  wire logic  trn_tdst_rdy_n,
    output logic       cfg_interrupt_n,
    input  wire logic  cfg_interrupt_rdy_n
);

    logic      last_tx;                           // Tx side served last
    logic      granted;
    logic      irq_pend;
    tlp_beat_t sel;

    assign granted  = rx_grant || tx_grant;
    assign sel      = tx_grant ? tx_beat : rx_beat;
    assign rx_ready = rx_grant && !trn_tdst_rdy_n;
    assign tx_ready = tx_grant && !trn_tdst_rdy_n;

    assign trn_td          = sel.data;
    assign trn_tsof_n      = !(granted && sel.sof);
    assign trn_teof_n      = !(granted && sel.eof);
    assign trn_tsrc_rdy_n  = !granted;
    assign cfg_interrupt_n = !irq_pend;

    // ------------------------------------------------------------------------
    // Ownership, released for one cycle after each eof
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            rx_grant <= 1'b0;
            tx_grant <= 1'b0;
            last_tx  <= 1'b0;
        end else if (granted) begin
            if (!trn_tdst_rdy_n && sel.eof) begin
                rx_grant <= 1'b0;
                tx_grant <= 1'b0;
            end
        end else if (rx_req && (!tx_req || last_tx)) begin
            rx_grant <= 1'b1;
            last_tx  <= 1'b0;
        end else if (tx_req) begin
            tx_grant <= 1'b1;
            last_tx  <= 1'b1;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (rst)
            irq_pend <= 1'b0;
        else if (irq_req && irq_en)
            irq_pend <= 1'b1;                     // New request beats the ack
        else if (!cfg_interrupt_rdy_n)
            irq_pend <= 1'b0;
    end

    a_one_owner: assert property (@(posedge trn_clk) disable iff (rst)
        !(rx_grant && tx_grant));

endmodule

`default_nettype wire

// File: pcie_endpoint_driver.sv
// Top of the endpoint DMA driver. Wires the BAR0 decoder, both TLP generators
// and the TX arbiter onto the core's TRN link and receive buffer.
`timescale 1ns/1ps
`default_nettype none

module pcie_endpoint_driver import pcie_dma_pkg::*; (
    input  wire logic              trn_clk,
    input  wire logic              rst,
    input  wire logic [QW_W-1:0]   trn_rd,
    input  wire logic              trn_rsof_n,
    input  wire logic              trn_reof_n,
    input  wire logic              trn_rsrc_rdy_n,
    input  wire logic [6:0]        trn_rbar_hit_n,
    output logic [QW_W-1:0]        trn_td,
    output logic                   trn_tsof_n,
    output logic                   trn_teof_n,
    output logic                   trn_tsrc_rdy_n,
    input  wire logic              trn_tdst_rdy_n,
    input  wire logic [7:0]        cfg_bus_number,
    input  wire logic [4:0]        cfg_device_number,
    input  wire logic [2:0]        cfg_function_number,
    input  wire logic [BUF_AW-1:0] rx_commited_wr_addr,
    output logic [BUF_AW-1:0]      rx_commited_rd_addr,
    output logic [BUF_AW-1:0]      rx_rd_addr,
    input  wire logic [QW_W-1:0]   rx_rd_data,
    output logic                   cfg_interrupt_n,
    input  wire logic              cfg_interrupt_rdy_n
);

    host_cfg_t           host_cfg;
    logic                tx_rd_start;
    logic [RD_LEN_W-1:0] tx_rd_qwords;
    logic                rx_req, rx_grant, rx_ready, irq_req;
    logic                tx_req, tx_grant, tx_ready;
    tlp_beat_t           rx_beat, tx_beat;

    host_reg_decoder u_regs (
        .trn_clk, .rst, .trn_rd, .trn_rsof_n, .trn_reof_n, .trn_rsrc_rdy_n,
        .trn_rbar_hit_n, .host_cfg, .tx_rd_start, .tx_rd_qwords
    );

    rx_mwr_tlp_gen u_rx (
        .trn_clk, .rst,
        .cfg_completer_id ({cfg_bus_number, cfg_device_number, cfg_function_number}),
        .host_cfg, .rx_commited_wr_addr, .rx_commited_rd_addr, .rx_rd_addr, .rx_rd_data,
        .req (rx_req), .grant (rx_grant), .ready (rx_ready), .beat (rx_beat), .irq_req
    );

    tx_mrd_req_gen u_tx (
        .trn_clk, .rst,
        .cfg_completer_id ({cfg_bus_number, cfg_device_number, cfg_function_number}),
        .host_cfg, .tx_rd_start, .tx_rd_qwords,
        .req (tx_req), .grant (tx_grant), .ready (tx_ready), .beat (tx_beat)
    );

    tlp_tx_arbiter u_arb (
        .trn_clk, .rst,
        .rx_req, .rx_grant, .rx_ready, .rx_beat,
        .tx_req, .tx_grant, .tx_ready, .tx_beat,
        .irq_req, .irq_en (host_cfg.irq_en),
        .trn_td, .trn_tsof_n, .trn_teof_n, .trn_tsrc_rdy_n, .trn_tdst_rdy_n,
        .cfg_interrupt_n, .cfg_interrupt_rdy_n
    );

endmodule

`default_nettype wire

// File: tb_pcie_endpoint_driver.sv
// Testbench for the PCIe endpoint DMA driver. Models the receive buffer and
// the host side of the TRN link, collects every accepted TX beat into TLPs
// and checks them against the TLP layout rules with assertions.
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_endpoint_driver import pcie_dma_pkg::*; ();

    localparam int TEST_CYCLES = 16 + 160 + 90 + 420 + 200;   // Sum over all tests
    localparam int CYCLE_LIMIT = 3 * TEST_CYCLES;              // Back-pressure margin

    logic              trn_clk, rst;
    logic [QW_W-1:0]   trn_rd, trn_td, rx_rd_data;
    logic              trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n;
    logic [6:0]        trn_rbar_hit_n;
    logic              trn_tsof_n, trn_teof_n, trn_tsrc_rdy_n, trn_tdst_rdy_n;
    logic [7:0]        cfg_bus_number;
    logic [4:0]        cfg_device_number;
    logic [2:0]        cfg_function_number;
    logic [BUF_AW-1:0] rx_commited_wr_addr, rx_commited_rd_addr, rx_rd_addr, rd_addr_q;
    logic              cfg_interrupt_n, cfg_interrupt_rdy_n;
    logic [15:0]       cpl_id;
    logic              taken, in_tlp, bp_on, irq_allowed, irq_n_prev;
    logic [31:0]       lfsr, rnd;
    logic [63:0]       rx_page, tx_page;
    logic [BUF_AW-1:0] rd_model;                 // Next buffer word expected
    logic [3:0]        tag_model;
    logic [63:0]       tlp_q[$];                 // Beats of the open TLP
    int                exp_rd_q[$];              // Qword counts of reads in flight
    int                rd_lens[3];               // Fixed read sizes of the read test
    int                rx_ofs, tx_ofs, mwr_cnt, mrd_cnt, irq_cnt, irq_wait, cycles;
    int                errors, checks, test_err0, tests_run, tests_failed;

    pcie_endpoint_driver u_dut (.*);

    assign cpl_id = {cfg_bus_number, cfg_device_number, cfg_function_number};
    assign taken  = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;

    initial begin
        trn_clk = 1'b0;
        forever #10 trn_clk = ~trn_clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [63:0] buf_word(logic [BUF_AW-1:0] a);
        return {16'hd5a0, 7'd0, a, 16'h3c3c, 7'd0, ~a};
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        a_value: assert (act === exp) else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic host_write(input logic [3:0] num, input logic [31:0] val);
        @(posedge trn_clk);
        #1;
        trn_rd         = {1'b0, FMT_MWR32, 14'd0, 10'd1, 32'h0000_000f};  // 1 DW MWr
        trn_rsof_n     = 1'b0;
        trn_rsrc_rdy_n = 1'b0;
        @(posedge trn_clk);
        #1;
        trn_rd     = {26'd0, num, 2'b00, val};   // Address DW, then data DW
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b0;
        @(posedge trn_clk);
        #1;
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0)
            tests_failed++;
        $display("test %-18s %s", name, errors == test_err0 ? "passed" : "failed");
        test_err0 = errors;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge trn_clk);
    endtask

    // Header, address and payload of one finished TLP
    task automatic check_tlp();
        logic [63:0] hdr;
        int          i;
        int          n;
        hdr = tlp_q[0];
        if (hdr[62:56] == FMT_MWR64) begin
            expect_eq("mwr_beats", 18, tlp_q.size());
            expect_eq("mwr_header", {1'b0, FMT_MWR64, 14'd0, 10'd32, cpl_id, 8'd0, 8'hff}, hdr);
            if (tlp_q.size() == 18) begin
                expect_eq("mwr_addr", rx_page + 64'(rx_ofs), tlp_q[1]);
                for (i = 0; i < MWR_QWORDS; i++)
                    expect_eq("mwr_payload", buf_word(rd_model + BUF_AW'(i)), tlp_q[2 + i]);
            end
            rd_model += BUF_AW'(MWR_QWORDS);
            rx_ofs    = (rx_ofs + MWR_BYTES) % PAGE_BYTES;
            mwr_cnt++;
        end else if (hdr[62:56] == FMT_MRD64 && exp_rd_q.size() != 0) begin
            n = exp_rd_q.pop_front();
            expect_eq("mrd_beats", 2, tlp_q.size());
            expect_eq("mrd_header",
                      {1'b0, FMT_MRD64, 14'd0, 10'(2 * n), cpl_id, 4'd0, tag_model, 8'hff}, hdr);
            if (tlp_q.size() == 2)
                expect_eq("mrd_addr", tx_page + 64'(tx_ofs), tlp_q[1]);
            tag_model++;
            tx_ofs = (tx_ofs + 8 * n) % PAGE_BYTES;
            mrd_cnt++;
        end else begin
            errors++;
            $display("TX TLP with unexpected header %h at %0t", hdr, $time);
        end
    endtask

    // ------------------------------------------------------------------------
    // Models: receive buffer, back-pressure, interrupt ack, beat collector
    // ------------------------------------------------------------------------
    always @(posedge trn_clk) begin
        rd_addr_q = rx_rd_addr;                  // One cycle read latency
        #1;
        rx_rd_data = buf_word(rd_addr_q);
    end

    always @(posedge trn_clk) begin
        #1;
        if (bp_on) begin
            rand_bits(1, rnd);
            trn_tdst_rdy_n = rnd[0];             // About half the cycles stalled
        end else begin
            trn_tdst_rdy_n = 1'b0;
        end
        if (!cfg_interrupt_n && cfg_interrupt_rdy_n && irq_wait == 2) begin
            cfg_interrupt_rdy_n = 1'b0;          // Core takes the interrupt
            irq_wait            = 0;
        end else begin
            cfg_interrupt_rdy_n = 1'b1;
            if (!cfg_interrupt_n)
                irq_wait++;
        end
    end

    always @(negedge trn_clk) begin
        if (!rst) begin
            if (taken) begin
                tlp_q.push_back(trn_td);
                if (!trn_teof_n) begin
                    check_tlp();
                    tlp_q.delete();
                end
            end
            if (irq_n_prev && !cfg_interrupt_n)
                irq_cnt++;
            irq_n_prev = cfg_interrupt_n;
        end
    end

    always @(posedge trn_clk) begin
        if (rst)
            in_tlp <= 1'b0;
        else if (taken)
            in_tlp <= trn_teof_n;
    end

    a_sof_opens: assert property (@(posedge trn_clk) disable iff (rst)
        taken && !trn_tsof_n |-> !in_tlp) else begin
        errors++;
        $display("sof inside an open TLP at %0t", $time);
    end
    a_no_stray: assert property (@(posedge trn_clk) disable iff (rst)
        taken && trn_tsof_n |-> in_tlp) else begin
        errors++;
        $display("beat outside any TLP at %0t", $time);
    end
    a_irq_ack: assert property (@(posedge trn_clk) disable iff (rst)
        !cfg_interrupt_rdy_n |=> cfg_interrupt_n) else begin
        errors++;
        $display("interrupt still low after ack at %0t", $time);
    end
    a_irq_off: assert property (@(posedge trn_clk) disable iff (rst)
        !irq_allowed |-> cfg_interrupt_n) else begin
        errors++;
        $display("interrupt raised while disabled at %0t", $time);
    end

    always @(posedge trn_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        {trn_rd, trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n} = {64'd0, 3'b111};
        trn_rbar_hit_n      = 7'b111_1110;       // BAR0 hit
        trn_tdst_rdy_n      = 1'b0;
        cfg_bus_number      = 8'h5a;
        cfg_device_number   = 5'h13;
        cfg_function_number = 3'h6;
        rx_commited_wr_addr = '0;
        cfg_interrupt_rdy_n = 1'b1;
        rx_rd_data          = '0;
        {bp_on, irq_allowed, irq_n_prev, in_tlp} = 4'b0010;
        {lfsr, rd_model, tag_model} = {32'h3990_4bb2, 9'd0, 4'd0};
        {rx_page, tx_page} = {64'h0000_0012_3460_0000, 64'h0000_0abc_0020_0000};
        rd_lens = '{1, 7, 64};
        {rx_ofs, tx_ofs, mwr_cnt, mrd_cnt, irq_cnt, irq_wait, cycles} = '0;
        {errors, checks, test_err0, tests_run, tests_failed} = '0;
        rst = 1'b1;
        repeat (16) @(posedge trn_clk);
        #1;
        rst = 1'b0;

        wait_cycles(2);
        expect_eq("reset_tsrc_rdy_n", 1, trn_tsrc_rdy_n);
        expect_eq("reset_tsof_n", 1, trn_tsof_n);
        expect_eq("reset_teof_n", 1, trn_teof_n);
        expect_eq("reset_interrupt_n", 1, cfg_interrupt_n);
        expect_eq("reset_commited_rd", 0, rx_commited_rd_addr);
        end_test("reset_state");

        host_write(REG_RX_PAGE_LO, rx_page[31:0]);
        host_write(REG_RX_PAGE_HI, rx_page[63:32]);
        @(posedge trn_clk);
        #1;
        rx_commited_wr_addr = 9'd40;             // Two full writes, 8 words left
        while (mwr_cnt < 2)
            @(negedge trn_clk);
        wait_cycles(40);
        expect_eq("rx_write_count", 2, mwr_cnt);
        expect_eq("rx_commited_rd", 32, rx_commited_rd_addr);
        end_test("rx_writes");

        host_write(REG_TX_PAGE_LO, tx_page[31:0]);
        host_write(REG_TX_PAGE_HI, tx_page[63:32]);
        foreach (rd_lens[i]) begin
            exp_rd_q.push_back(rd_lens[i]);
            host_write(REG_TX_RD_QWORDS, 32'(rd_lens[i]));
            while (mrd_cnt < i + 1)
                @(negedge trn_clk);
        end
        end_test("tx_reads");

        bp_on = 1'b1;
        @(posedge trn_clk);
        #1;
        rx_commited_wr_addr = 9'd104;            // Four more writes
        repeat (3) begin
            @(negedge trn_clk);
            rand_bits(6, rnd);
            exp_rd_q.push_back(int'(rnd[5:0]) + 1);
            host_write(REG_TX_RD_QWORDS, rnd[5:0] + 32'd1);
            while (exp_rd_q.size() != 0)
                @(negedge trn_clk);
        end
        while (mwr_cnt < 6)
            @(negedge trn_clk);
        bp_on = 1'b0;
        expect_eq("bp_read_count", 6, mrd_cnt);
        end_test("backpressure_arb");

        irq_allowed = 1'b1;
        host_write(REG_CTRL, 32'd1);
        @(posedge trn_clk);
        #1;
        rx_commited_wr_addr = 9'd136;
        while (irq_cnt < 2)
            @(negedge trn_clk);
        while (!cfg_interrupt_n)
            @(negedge trn_clk);
        host_write(REG_CTRL, 32'd0);
        wait_cycles(2);
        irq_allowed = 1'b0;
        @(posedge trn_clk);
        #1;
        rx_commited_wr_addr = 9'd152;            // One write with irq off
        while (mwr_cnt < 9)
            @(negedge trn_clk);
        wait_cycles(20);
        expect_eq("irq_count", 2, irq_cnt);
        end_test("interrupt");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: pcie_endpoint_driver.f
pcie_dma_pkg.sv
host_reg_decoder.sv
rx_mwr_tlp_gen.sv
tx_mrd_req_gen.sv
tlp_tx_arbiter.sv
pcie_endpoint_driver.sv
tb_pcie_endpoint_driver.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_pcie_endpoint_driver
RTL_TOP   := pcie_endpoint_driver
FILELIST  := pcie_endpoint_driver.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT      := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
